// File: verilog/mem_pkg.sv
package mem_pkg;

    // memory geometry
    localparam int num_groups = 4;
    localparam int num_banks  = 4;
    localparam int bank_rows  = 64;

    // rt0, rt1, mc
    localparam int num_ports = 3;

    // byte address as seen on a port
    typedef logic [31:0] addr_t;

    // one bank word
    typedef logic [31:0] word_t;

    // word k sits at bits 32k+31 to 32k
    typedef logic [127:0] line_t;

    // thread group, address bits 11:10
    typedef logic [1:0] group_t;

    // bank index, the start bank is address bits 3:2
    typedef logic [1:0] bank_sel_t;

    typedef logic [5:0] row_t;

    // bit 0 rt0, bit 1 rt1, bit 2 mc
    typedef logic [2:0] port_vec_t;

endpackage

// File: verilog/mem_req_decode.sv
module mem_req_decode
    import mem_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic                                   rt0_req,
    input  logic                                   rt0_we,
    input  addr_t                                  rt0_addr,
    input  line_t                                  rt0_wdata,

    input  logic                                   rt1_req,
    input  logic                                   rt1_we,
    input  addr_t                                  rt1_addr,
    input  line_t                                  rt1_wdata,

    input  logic                                   mc_req,
    input  addr_t                                  mc_addr,

    input  port_vec_t                              done,

    output logic      [num_groups-1:0]             grp_en,
    output logic      [num_groups-1:0]             grp_we,
    output row_t      [num_groups-1:0][num_banks-1:0] grp_row,
    output word_t     [num_groups-1:0][num_banks-1:0] grp_wdata,

    output port_vec_t                              iss_valid,
    output group_t    [num_ports-1:0]              iss_group,
    output bank_sel_t [num_ports-1:0]              iss_start
);

    port_vec_t                 req_vec;
    port_vec_t                 req_we;
    addr_t  [num_ports-1:0]    req_addr;
    line_t  [num_ports-1:0]    req_wdata;
    group_t [num_ports-1:0]    req_group;

    port_vec_t                 pending;
    port_vec_t                 eligible;
    port_vec_t                 grant;

    logic   [num_groups-1:0]   grp_hit;
    logic   [num_groups-1:0][1:0] grp_port;
    row_t   [num_groups-1:0][num_banks-1:0] row_nxt;
    word_t  [num_groups-1:0][num_banks-1:0] wdata_nxt;

    // mc is read-only
    assign req_vec   = {mc_req, rt1_req, rt0_req};
    assign req_we    = {1'b0, rt1_we, rt0_we};
    assign req_addr  = {mc_addr, rt1_addr, rt0_addr};
    assign req_wdata = {line_t'(0), rt1_wdata, rt0_wdata};

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            req_group[p] = req_addr[p][11:10];
        end
    end

    // a port in flight ignores req until its rdy cycle is over
    assign eligible = req_vec & ~pending;

    // fixed priority per group, lower port index wins
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            grant[p] = eligible[p];
            for (int q = 0; q < p; q++) begin
                if (eligible[q] && req_group[q] == req_group[p]) begin
                    grant[p] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending | grant) & ~done;
        end
    end

    // at most one granted port per group
    always_comb begin
        for (int g = 0; g < num_groups; g++) begin
            grp_hit[g]  = 1'b0;
            grp_port[g] = 2'd0;
            for (int p = 0; p < num_ports; p++) begin
                if (grant[p] && req_group[p] == group_t'(g)) begin
                    grp_hit[g]  = 1'b1;
                    grp_port[g] = 2'(p);
                end
            end
        end
    end

    // rotate the line across the banks of each group
    always_comb begin : rotate
        addr_t     sel_addr;
        bank_sel_t start;
        bank_sel_t k;
        for (int g = 0; g < num_groups; g++) begin
            sel_addr = req_addr[grp_port[g]];
            start    = sel_addr[3:2];
            for (int b = 0; b < num_banks; b++) begin
                k = bank_sel_t'(b) - start;
                // banks below the start bank hold the tail of the line, one row on
                if (bank_sel_t'(b) < start) begin
                    row_nxt[g][b] = sel_addr[9:4] + row_t'(1);
                end else begin
                    row_nxt[g][b] = sel_addr[9:4];
                end
                wdata_nxt[g][b] = req_wdata[grp_port[g]][k*32 +: 32];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grp_en    <= '0;
            grp_we    <= '0;
            iss_valid <= '0;
        end else begin
            iss_valid <= grant;
            for (int g = 0; g < num_groups; g++) begin
                grp_en[g] <= grp_hit[g];
                grp_we[g] <= grp_hit[g] && req_we[grp_port[g]];
            end
        end
    end

    always_ff @(posedge clk) begin
        grp_row   <= row_nxt;
        grp_wdata <= wdata_nxt;
        for (int p = 0; p < num_ports; p++) begin
            iss_group[p] <= req_group[p];
            iss_start[p] <= req_addr[p][3:2];
        end
    end

endmodule

// File: verilog/mem_bank_array.sv
module mem_bank_array
    import mem_pkg::*;
(
    input  logic                                 clk,

    input  logic  [num_groups-1:0]               grp_en,
    input  logic  [num_groups-1:0]               grp_we,
    input  row_t  [num_groups-1:0][num_banks-1:0] grp_row,
    input  word_t [num_groups-1:0][num_banks-1:0] grp_wdata,

    output word_t [num_groups-1:0][num_banks-1:0] grp_q
);

    // one word-wide memory per bank, all banks of a group share en and we
    for (genvar g = 0; g < num_groups; g++) begin : g_group
        for (genvar b = 0; b < num_banks; b++) begin : g_bank

            word_t mem [bank_rows];
            word_t q;

            // read-first, a write cycle returns the old word
            always_ff @(posedge clk) begin
                if (grp_en[g]) begin
                    if (grp_we[g]) begin
                        mem[grp_row[g][b]] <= grp_wdata[g][b];
                    end
                    q <= mem[grp_row[g][b]];
                end
            end

            assign grp_q[g][b] = q;

        end
    end

endmodule

// File: verilog/mem_read_result.sv
module mem_read_result
    import mem_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,

    input  port_vec_t                            iss_valid,
    input  group_t    [num_ports-1:0]            iss_group,
    input  bank_sel_t [num_ports-1:0]            iss_start,
    input  word_t     [num_groups-1:0][num_banks-1:0] grp_q,

    output logic                                 rt0_rdy,
    output line_t                                rt0_rdata,
    output logic                                 rt1_rdy,
    output line_t                                rt1_rdata,
    output logic                                 mc_rdy,
    output line_t                                mc_rdata,

    output port_vec_t                            done
);

    port_vec_t                   valid_d;
    group_t    [num_ports-1:0]   group_d;
    bank_sel_t [num_ports-1:0]   start_d;

    line_t     [num_ports-1:0]   line_sel;
    port_vec_t                   rdy_q;
    line_t     [num_ports-1:0]   rdata_q;

    // issue info one cycle late, in step with the bank outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= '0;
            rdy_q   <= '0;
        end else begin
            valid_d <= iss_valid;
            rdy_q   <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        group_d <= iss_group;
        start_d <= iss_start;
        for (int p = 0; p < num_ports; p++) begin
            if (valid_d[p]) begin
                rdata_q[p] <= line_sel[p];
            end
        end
    end

    // undo the rotation: word k comes from bank start+k
    always_comb begin : unrotate
        bank_sel_t bk;
        for (int p = 0; p < num_ports; p++) begin
            for (int k = 0; k < num_banks; k++) begin
                bk = start_d[p] + bank_sel_t'(k);
                line_sel[p][k*32 +: 32] = grp_q[group_d[p]][bk];
            end
        end
    end

    assign rt0_rdy   = rdy_q[0];
    assign rt1_rdy   = rdy_q[1];
    assign mc_rdy    = rdy_q[2];
    assign rt0_rdata = rdata_q[0];
    assign rt1_rdata = rdata_q[1];
    assign mc_rdata  = rdata_q[2];

    // frees the pending bit in decode
    assign done = rdy_q;

endmodule

// File: verilog/banked_mem_top.sv
module banked_mem_top
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  rt0_req,
    input  logic  rt0_we,
    input  addr_t rt0_addr,
    input  line_t rt0_wdata,
    output logic  rt0_rdy,
    output line_t rt0_rdata,

    input  logic  rt1_req,
    input  logic  rt1_we,
    input  addr_t rt1_addr,
    input  line_t rt1_wdata,
    output logic  rt1_rdy,
    output line_t rt1_rdata,

    input  logic  mc_req,
    input  addr_t mc_addr,
    output logic  mc_rdy,
    output line_t mc_rdata
);

    logic      [num_groups-1:0]                grp_en;
    logic      [num_groups-1:0]                grp_we;
    row_t      [num_groups-1:0][num_banks-1:0] grp_row;
    word_t     [num_groups-1:0][num_banks-1:0] grp_wdata;
    word_t     [num_groups-1:0][num_banks-1:0] grp_q;

    port_vec_t                                 iss_valid;
    group_t    [num_ports-1:0]                 iss_group;
    bank_sel_t [num_ports-1:0]                 iss_start;
    port_vec_t                                 done;

    mem_req_decode i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .rt0_req   (rt0_req),
        .rt0_we    (rt0_we),
        .rt0_addr  (rt0_addr),
        .rt0_wdata (rt0_wdata),
        .rt1_req   (rt1_req),
        .rt1_we    (rt1_we),
        .rt1_addr  (rt1_addr),
        .rt1_wdata (rt1_wdata),
        .mc_req    (mc_req),
        .mc_addr   (mc_addr),
        .done      (done),
        .grp_en    (grp_en),
        .grp_we    (grp_we),
        .grp_row   (grp_row),
        .grp_wdata (grp_wdata),
        .iss_valid (iss_valid),
        .iss_group (iss_group),
        .iss_start (iss_start)
    );

    mem_bank_array i_banks (
        .clk       (clk),
        .grp_en    (grp_en),
        .grp_we    (grp_we),
        .grp_row   (grp_row),
        .grp_wdata (grp_wdata),
        .grp_q     (grp_q)
    );

    mem_read_result i_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_group (iss_group),
        .iss_start (iss_start),
        .grp_q     (grp_q),
        .rt0_rdy   (rt0_rdy),
        .rt0_rdata (rt0_rdata),
        .rt1_rdy   (rt1_rdy),
        .rt1_rdata (rt1_rdata),
        .mc_rdy    (mc_rdy),
        .mc_rdata  (mc_rdata),
        .done      (done)
    );

endmodule

// File: tests/banked_mem_props.sv
module banked_mem_props (
    input logic clk,
    input logic rst_n,
    input logic rt0_req,
    input logic rt0_rdy,
    input logic rt1_req,
    input logic rt1_rdy,
    input logic mc_req,
    input logic mc_rdy
);

    logic rt0_busy;

    // rt0 in flight from its grant up to the edge that ends its rdy pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt0_busy <= 1'b0;
        end else if (rt0_rdy) begin
            rt0_busy <= 1'b0;
        end else if (rt0_req) begin
            rt0_busy <= 1'b1;
        end
    end

    rt0_pulse: assert property (@(posedge clk) disable iff (!rst_n) rt0_rdy |=> !rt0_rdy)
        else $error("rt0_rdy high on two consecutive cycles");
    rt1_pulse: assert property (@(posedge clk) disable iff (!rst_n) rt1_rdy |=> !rt1_rdy)
        else $error("rt1_rdy high on two consecutive cycles");
    mc_pulse: assert property (@(posedge clk) disable iff (!rst_n) mc_rdy |=> !mc_rdy)
        else $error("mc_rdy high on two consecutive cycles");

    rt0_with_req: assert property (@(posedge clk) disable iff (!rst_n) rt0_rdy |-> rt0_req)
        else $error("rt0_rdy high without rt0_req");
    rt1_with_req: assert property (@(posedge clk) disable iff (!rst_n) rt1_rdy |-> rt1_req)
        else $error("rt1_rdy high without rt1_req");
    mc_with_req: assert property (@(posedge clk) disable iff (!rst_n) mc_rdy |-> mc_req)
        else $error("mc_rdy high without mc_req");

    // rt0 always wins its group, so its latency is fixed
    rt0_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rt0_req && !rt0_busy |=> !rt0_rdy ##1 !rt0_rdy ##1 rt0_rdy)
        else $error("rt0_rdy not at the third edge after the grant");

endmodule

bind banked_mem_top banked_mem_props i_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .rt0_req (rt0_req),
    .rt0_rdy (rt0_rdy),
    .rt1_req (rt1_req),
    .rt1_rdy (rt1_rdy),
    .mc_req  (mc_req),
    .mc_rdy  (mc_rdy)
);

// File: tests/banked_mem_tb.sv
module banked_mem_tb
    import mem_pkg::*;
();

    localparam int timeout_cycles = 20;

    logic  clk       = 1'b0;
    logic  rst_n     = 1'b0;
    logic  rt0_req   = 1'b0;
    logic  rt0_we    = 1'b0;
    addr_t rt0_addr  = '0;
    line_t rt0_wdata = '0;
    logic  rt0_rdy;
    line_t rt0_rdata;
    logic  rt1_req   = 1'b0;
    logic  rt1_we    = 1'b0;
    addr_t rt1_addr  = '0;
    line_t rt1_wdata = '0;
    logic  rt1_rdy;
    line_t rt1_rdata;
    logic  mc_req    = 1'b0;
    addr_t mc_addr   = '0;
    logic  mc_rdy;
    line_t mc_rdata;

    logic  [2:0] rdy_vec;
    line_t       rdata_vec [3];
    string       rdata_names [3] = '{"rt0_rdata", "rt1_rdata", "mc_rdata"};

    // flat model, word w of group g at g*256 + w
    word_t  model [num_groups*256];
    line_t  exp_line [3];
    bit     exp_read [3];
    int     lat [3];
    int     rdy_order [$];
    integer seed;

    banked_mem_top i_dut (.*);

    always #20 clk = ~clk;

    assign rdy_vec = {mc_rdy, rt1_rdy, rt0_rdy};

    always_comb begin
        rdata_vec[0] = rt0_rdata;
        rdata_vec[1] = rt1_rdata;
        rdata_vec[2] = mc_rdata;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    function automatic addr_t make_addr(input group_t g, input logic [7:0] w);
        return addr_t'({g, w, 2'b00});
    endfunction

    // word k of the line is word (start + k) mod 256 of the same group
    function automatic line_t ref_line(input addr_t addr);
        line_t l;
        int    base;
        base = int'(addr[11:10]) * 256;
        for (int k = 0; k < num_banks; k++) begin
            l[k*32 +: 32] = model[base + (int'(addr[9:2]) + k) % 256];
        end
        return l;
    endfunction

    function automatic line_t fill_line(input int idx);
        line_t l;
        for (int k = 0; k < num_banks; k++) begin
            l[k*32 +: 32] = word_t'(idx * 4 + k) * 32'h9e37_79b1 + 32'h0bad_f00d;
        end
        return l;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < num_banks; k++) begin
            l[k*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // model side of a request, called in priority order
    task automatic issue_op(input int port, input bit we, input addr_t addr, input line_t data);
        int base;
        base = int'(addr[11:10]) * 256;
        exp_read[port] = !we;
        if (we) begin
            for (int k = 0; k < num_banks; k++) begin
                model[base + (int'(addr[9:2]) + k) % 256] = data[k*32 +: 32];
            end
        end else begin
            exp_line[port] = ref_line(addr);
        end
    endtask

    task automatic run_port(input int port, input bit we, input addr_t addr, input line_t data);
        int cycles;
        case (port)
            0: begin
                rt0_we    = we;
                rt0_addr  = addr;
                rt0_wdata = data;
                rt0_req   = 1'b1;
            end
            1: begin
                rt1_we    = we;
                rt1_addr  = addr;
                rt1_wdata = data;
                rt1_req   = 1'b1;
            end
            default: begin
                mc_addr = addr;
                mc_req  = 1'b1;
            end
        endcase
        @(negedge clk);
        cycles = 1;
        while (!rdy_vec[port]) begin
            if (cycles >= timeout_cycles) begin
                stop_on_error($sformatf("%s: no rdy within timeout", rdata_names[port]));
            end
            @(negedge clk);
            cycles++;
        end
        lat[port] = cycles;
        // req stays up through the rdy cycle
        @(negedge clk);
        case (port)
            0: rt0_req = 1'b0;
            1: rt1_req = 1'b0;
            default: mc_req = 1'b0;
        endcase
    endtask

    task automatic access(input int port, input bit we, input addr_t addr, input line_t data);
        issue_op(port, we, addr, data);
        run_port(port, we, addr, data);
    endtask

    task automatic check_rt0_latency();
        assert (lat[0] == 3)
            else stop_on_error($sformatf("mismatch at %0t: rt0_rdy latency is %0d, expected 3",
                $time, lat[0]));
    endtask

    always @(negedge clk) begin
        for (int p = 0; p < 3; p++) begin
            if (rst_n && rdy_vec[p]) begin
                rdy_order.push_back(p);
                if (exp_read[p]) begin
                    assert (rdata_vec[p] == exp_line[p])
                        else stop_on_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                            $time, rdata_names[p], rdata_vec[p], exp_line[p]));
                end
            end
        end
    end

    initial begin
        line_t  d0;
        line_t  d1;
        addr_t  a0;
        addr_t  a1;
        bit     w0;
        bit     w1;
        group_t g2;
        seed = 13;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // groups 0 and 1 through rt0, groups 2 and 3 through rt1
        for (int i = 0; i < 128; i++) begin
            fork
                access(0, 1'b1, addr_t'(i * 16), fill_line(i));
                access(1, 1'b1, addr_t'((i + 128) * 16), fill_line(i + 128));
            join
        end

        d0 = random_line();
        access(0, 1'b1, make_addr(2'd0, 8'd16), d0);
        check_rt0_latency();
        access(0, 1'b0, make_addr(2'd0, 8'd16), '0);
        check_rt0_latency();

        // start bank 1, then one word further on
        access(1, 1'b1, make_addr(2'd1, 8'd37), random_line());
        access(1, 1'b0, make_addr(2'd1, 8'd37), '0);
        access(1, 1'b0, make_addr(2'd1, 8'd38), '0);

        access(0, 1'b1, make_addr(2'd2, 8'd254), random_line());
        access(0, 1'b0, make_addr(2'd2, 8'd254), '0);
        access(1, 1'b0, make_addr(2'd2, 8'd0), '0);

        fork
            access(0, 1'b0, make_addr(2'd0, 8'd5), '0);
            access(1, 1'b0, make_addr(2'd1, 8'd77), '0);
            access(2, 1'b0, make_addr(2'd3, 8'd200), '0);
        join

        rdy_order.delete();
        issue_op(0, 1'b0, make_addr(2'd3, 8'd10), '0);
        issue_op(1, 1'b0, make_addr(2'd3, 8'd99), '0);
        issue_op(2, 1'b0, make_addr(2'd3, 8'd255), '0);
        fork
            run_port(0, 1'b0, make_addr(2'd3, 8'd10), '0);
            run_port(1, 1'b0, make_addr(2'd3, 8'd99), '0);
            run_port(2, 1'b0, make_addr(2'd3, 8'd255), '0);
        join
        assert (rdy_order.size() == 3 && rdy_order[0] == 0 && rdy_order[1] == 1
                && rdy_order[2] == 2)
            else stop_on_error("rdy pulses for one group did not come in order rt0, rt1, mc");

        for (int n = 0; n < 70; n++) begin
            w0 = ($random(seed) & 1) != 0;
            w1 = ($random(seed) & 1) != 0;
            a0 = make_addr(group_t'($random(seed)), 8'($random(seed)));
            a1 = make_addr(group_t'($random(seed)), 8'($random(seed)));
            d0 = random_line();
            d1 = random_line();
            g2 = group_t'($random(seed));
            // mc stays out of groups written in this batch
            while ((w0 && g2 == a0[11:10]) || (w1 && g2 == a1[11:10])) begin
                g2 = g2 + 2'd1;
            end
            issue_op(0, w0, a0, d0);
            issue_op(1, w1, a1, d1);
            issue_op(2, 1'b0, make_addr(g2, 8'(n * 37)), '0);
            fork
                run_port(0, w0, a0, d0);
                run_port(1, w1, a1, d1);
                run_port(2, 1'b0, make_addr(g2, 8'(n * 37)), '0);
            join
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: project.f
verilog/mem_pkg.sv
verilog/mem_req_decode.sv
verilog/mem_bank_array.sv
verilog/mem_read_result.sv
verilog/banked_mem_top.sv
tests/banked_mem_props.sv
tests/banked_mem_tb.sv

// File: Makefile
# Verilator build and run for the banked memory testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := banked_mem_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
